// ==== sources.f ====
+incdir+testbench
hw/rv_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/alu.sv
hw/imm_gen.sv
hw/reg_file.sv
hw/control_fsm.sv
hw/datapath.sv
hw/cpu_core.sv
testbench/tb_memory.sv
testbench/tb_cpu_core.sv

// ==== testbench/tb_tests.svh ====
// Instruction encoders and the table of test programs with their expected stores
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

localparam int max_tests_c  = 8;
localparam int max_words_c  = 16;
localparam int max_stores_c = 8;

string test_name [max_tests_c];
int    prog_len  [max_tests_c];
word_t prog      [max_tests_c][max_words_c];
int    store_cnt [max_tests_c];
word_t exp_addr  [max_tests_c][max_stores_c];
word_t exp_data  [max_tests_c][max_stores_c];
int    n_tests = 0;

function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1, int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_op_c};
endfunction

function automatic word_t enc_i(logic [2:0] f3, int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), op_op_imm_c};
endfunction

function automatic word_t enc_lw(int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), 3'b010, 5'(rd), op_load_c};
endfunction

function automatic word_t enc_sw(int rs2, int rs1, int imm);
    logic [11:0] v;
    v = 12'(imm);
    return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], op_store_c};
endfunction

function automatic word_t enc_br(logic [2:0] f3, int rs1, int rs2, int off);
    logic [12:0] v;
    v = 13'(off);
    return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], op_branch_c};
endfunction

function automatic word_t enc_lui(int rd, logic [19:0] imm20);
    return {imm20, 5'(rd), op_lui_c};
endfunction

task automatic new_test(input string name);
    test_name[n_tests] = name;
    prog_len[n_tests]  = 0;
    store_cnt[n_tests] = 0;
    n_tests++;
endtask

task automatic add_word(input word_t w);
    prog[n_tests-1][prog_len[n_tests-1]] = w;
    prog_len[n_tests-1]++;
endtask

task automatic expect_store(input word_t addr, input word_t data);
    exp_addr[n_tests-1][store_cnt[n_tests-1]] = addr;
    exp_data[n_tests-1][store_cnt[n_tests-1]] = data;
    store_cnt[n_tests-1]++;
endtask

// Store to 0xfffc through x31 = 0x10000 ends the program
task automatic add_halt();
    add_word(enc_lui(31, 20'h00010));
    add_word(enc_sw(0, 31, -4));
endtask

// Not-taken branch falls through to the taken one which skips the bad store
task automatic add_branch_pair(input logic [2:0] f3, input int nt_a, input int nt_b,
                               input int t_a, input int t_b, input int mark_addr);
    add_word(enc_br(f3, nt_a, nt_b, 8));
    add_word(enc_br(f3, t_a, t_b, 8));
    add_word(enc_sw(1, 0, 'h7f0));
    add_word(enc_sw(2, 0, mark_addr));
    expect_store(mark_addr, 32'h1);
endtask

task automatic build_tests();
    new_test("alu_arith");
    add_word(enc_i(f3_add_c, 1, 0, -20));
    add_word(enc_i(f3_add_c, 2, 0, 7));
    add_word(enc_r(7'h00, f3_add_c, 3, 1, 2));
    add_word(enc_sw(3, 0, 'h100));
    add_word(enc_r(7'h20, f3_add_c, 4, 1, 2));
    add_word(enc_sw(4, 0, 'h104));
    add_word(enc_r(7'h00, f3_and_c, 5, 1, 2));
    add_word(enc_sw(5, 0, 'h108));
    add_word(enc_r(7'h00, f3_or_c, 6, 1, 2));
    add_word(enc_sw(6, 0, 'h10c));
    add_halt();
    expect_store(32'h100, 32'hffff_fff3);
    expect_store(32'h104, 32'hffff_ffe5);
    expect_store(32'h108, 32'h0000_0004);
    expect_store(32'h10c, 32'hffff_ffef);

    new_test("alu_shift");     // Shift amount 35 masks to 3
    add_word(enc_i(f3_add_c, 1, 0, -20));
    add_word(enc_i(f3_add_c, 2, 0, 35));
    add_word(enc_r(7'h00, f3_xor_c, 3, 1, 2));
    add_word(enc_sw(3, 0, 'h110));
    add_word(enc_r(7'h00, f3_sll_c, 4, 1, 2));
    add_word(enc_sw(4, 0, 'h114));
    add_word(enc_r(7'h00, f3_sr_c, 5, 1, 2));
    add_word(enc_sw(5, 0, 'h118));
    add_word(enc_r(7'h20, f3_sr_c, 6, 1, 2));
    add_word(enc_sw(6, 0, 'h11c));
    add_halt();
    expect_store(32'h110, 32'hffff_ffcf);
    expect_store(32'h114, 32'hffff_ff60);
    expect_store(32'h118, 32'h1fff_fffd);
    expect_store(32'h11c, 32'hffff_fffd);

    new_test("compare_x0");
    add_word(enc_i(f3_add_c, 1, 0, -1));
    add_word(enc_i(f3_add_c, 2, 0, 1));
    add_word(enc_r(7'h00, f3_slt_c, 3, 1, 2));     // -1 < 1
    add_word(enc_r(7'h00, f3_sltu_c, 4, 1, 2));    // 0xffffffff < 1 unsigned
    add_word(enc_i(f3_slt_c, 5, 1, 0));
    add_word(enc_i(f3_sltu_c, 6, 2, -1));
    add_word(enc_i(f3_add_c, 0, 2, 5));            // Write to x0
    add_word(enc_sw(3, 0, 'h120));
    add_word(enc_sw(4, 0, 'h124));
    add_word(enc_sw(5, 0, 'h128));
    add_word(enc_sw(6, 0, 'h12c));
    add_word(enc_sw(0, 0, 'h130));
    add_halt();
    expect_store(32'h120, 32'h1);
    expect_store(32'h124, 32'h0);
    expect_store(32'h128, 32'h1);
    expect_store(32'h12c, 32'h1);
    expect_store(32'h130, 32'h0);

    new_test("load_store");
    add_word(enc_i(f3_add_c, 1, 0, 'h200));
    add_word(enc_i(f3_add_c, 2, 0, -291));
    add_word(enc_sw(2, 1, 8));
    add_word(enc_sw(1, 1, -16));
    add_word(enc_lw(3, 1, 8));
    add_word(enc_lw(4, 1, -16));
    add_word(enc_sw(3, 1, 12));
    add_word(enc_sw(4, 1, -12));
    add_halt();
    expect_store(32'h208, 32'hffff_fedd);
    expect_store(32'h1f0, 32'h0000_0200);
    expect_store(32'h20c, 32'hffff_fedd);
    expect_store(32'h1f4, 32'h0000_0200);

    new_test("branch_eq_lt");  // x1 = -1, x2 = 1
    add_word(enc_i(f3_add_c, 1, 0, -1));
    add_word(enc_i(f3_add_c, 2, 0, 1));
    add_branch_pair(f3_beq_c, 1, 2, 2, 2, 'h140);
    add_branch_pair(f3_bne_c, 1, 1, 1, 2, 'h144);
    add_branch_pair(f3_blt_c, 2, 1, 1, 2, 'h148);
    add_halt();

    new_test("branch_ge_unsigned");
    add_word(enc_i(f3_add_c, 1, 0, -1));
    add_word(enc_i(f3_add_c, 2, 0, 1));
    add_branch_pair(f3_bge_c, 1, 2, 2, 1, 'h160);
    add_branch_pair(f3_bltu_c, 1, 2, 2, 1, 'h164);
    add_branch_pair(f3_bgeu_c, 2, 1, 1, 2, 'h168);
    add_halt();

    new_test("lui_unknown");
    add_word(enc_lui(5, 20'habcde));
    add_word(enc_sw(5, 0, 'h150));
    add_word(enc_i(f3_add_c, 6, 0, 'h55));
    add_word(32'hfff0_037f);                       // Opcode 0x7f with rd x6 is not decoded
    add_word(enc_sw(6, 0, 'h154));
    add_word(enc_sw(5, 0, 'h158));
    add_halt();
    expect_store(32'h150, 32'habcd_e000);
    expect_store(32'h154, 32'h0000_0055);
    expect_store(32'h158, 32'habcd_e000);
endtask

`endif

// ==== testbench/tb_cpu_core.sv ====
// Testbench top with clock, reset, table-driven test loop and value checks
`timescale 1ns/1ps

module tb_cpu_core import rv_isa_pkg::*, core_ctrl_pkg::*; ();

    localparam word_t halt_addr_c = 32'h0000_fffc;
    localparam int    reset_cyc_c = 16;

    logic     clk;
    logic     reset;
    word_t    mem_rdata;
    mem_req_t mem_req;
    integer   seed = 32'hee4;   // Fill of memory the program does not write
    int       cycles = 0;
    int       cycle_limit = 0;

    `include "tb_tests.svh"

    cpu_core i_dut (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req)
    );

    tb_memory i_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rdata   (mem_rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout, program did not reach halt");
            $display("TEST FAIL");
            $fatal(1, "cycle limit %0d reached", cycle_limit);
        end
    end

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %h, actual %h", what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "mismatch in %s", what);
        end
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < 16384; i++) begin
            i_mem.write_word(i, $random(seed) ^ i);
        end
        for (int i = 0; i < prog_len[t]; i++) begin
            i_mem.write_word(i, prog[t][i]);
        end
    endtask

    task automatic run_test(input int t);
        int   idx;
        logic done;
        idx  = 0;
        done = 1'b0;
        load_program(t);
        @(negedge clk);
        reset = 1'b1;
        repeat (reset_cyc_c) begin
            @(negedge clk);
            check_value($sformatf("%s write in reset", test_name[t]), 0, mem_req.write);
        end
        reset = 1'b0;
        #1;
        check_value($sformatf("%s first read", test_name[t]), 1, mem_req.read);
        check_value($sformatf("%s first addr", test_name[t]), 0, mem_req.addr);
        check_value($sformatf("%s first write", test_name[t]), 0, mem_req.write);
        while (!done) begin
            @(negedge clk);
            if (mem_req.write) begin
                if (mem_req.addr == halt_addr_c) begin
                    done = 1'b1;
                end else begin
                    // More stores than expected shows up as a count mismatch
                    if (idx >= store_cnt[t]) begin
                        check_value($sformatf("%s store count", test_name[t]),
                                    store_cnt[t], idx + 1);
                    end
                    check_value($sformatf("%s store %0d addr", test_name[t], idx),
                                exp_addr[t][idx], mem_req.addr);
                    check_value($sformatf("%s store %0d data", test_name[t], idx),
                                exp_data[t][idx], mem_req.wdata);
                    idx++;
                end
            end
        end
        check_value($sformatf("%s store count", test_name[t]), store_cnt[t], idx);
    endtask

    initial begin
        reset = 1'b1;
        build_tests();
        for (int t = 0; t < n_tests; t++) begin
            cycle_limit += 5 * prog_len[t] + 20;
        end
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== testbench/tb_memory.sv ====
// Word-addressed memory model behind the core's shared memory port
`timescale 1ns/1ps

module tb_memory import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic     clk,
    input  mem_req_t mem_req,
    output word_t    rdata
);

    localparam int depth_c = 16384;     // 64 KiB, covers the halt address

    word_t mem [0:depth_c-1];

    assign rdata = mem[mem_req.addr[15:2]];    // Combinational read

    always @(posedge clk) begin
        if (mem_req.write) begin
            mem[mem_req.addr[15:2]] <= mem_req.wdata;
        end
    end

    // Backdoor load from the testbench
    task automatic write_word(input int idx, input word_t data);
        mem[idx] = data;
    endtask

endmodule

// ==== hw/cpu_core.sv ====
// Multi-cycle RV32I core top level with control FSM and datapath
`timescale 1ns/1ps

module cpu_core import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    mem_rdata,
    output mem_req_t mem_req
);

    ctrl_t  ctrl;
    instr_t instr;

    control_fsm i_control_fsm (
        .clk   (clk),
        .reset (reset),
        .instr (instr),
        .ctrl  (ctrl)
    );

    datapath i_datapath (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .mem_req   (mem_req),
        .instr     (instr)
    );

endmodule

// ==== hw/datapath.sv ====
// Core datapath: PC, IR, temporary registers, operand muxes, write-back and branch decision
`timescale 1ns/1ps

module datapath import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  ctrl_t    ctrl,
    input  word_t    mem_rdata,
    output mem_req_t mem_req,
    output instr_t   instr
);

    word_t  pc;
    word_t  old_pc;     // PC of the instruction held in ir
    instr_t ir;
    word_t  a;
    word_t  b;
    word_t  alu_out;
    word_t  mdr;

    word_t  rdata1;
    word_t  rdata2;
    word_t  imm;
    word_t  alu_a;
    word_t  alu_b;
    word_t  alu_result;
    word_t  wb_data;
    logic   zero;
    logic   take_branch;

    reg_file i_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs1    (ir.r.rs1),
        .rs2    (ir.r.rs2),
        .rd     (ir.r.rd),
        .we     (ctrl.reg_write),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    imm_gen i_imm_gen (
        .instr (ir),
        .imm   (imm)
    );

    alu i_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    always_comb begin
        case (ctrl.src_a)
            src_a_pc:     alu_a = pc;
            src_a_old_pc: alu_a = old_pc;
            src_a_rs1:    alu_a = a;
            default:      alu_a = '0;
        endcase
    end

    always_comb begin
        case (ctrl.src_b)
            src_b_rs2:  alu_b = b;
            src_b_four: alu_b = pc_step_c;
            src_b_imm:  alu_b = imm;
            default:    alu_b = '0;
        endcase
    end

    assign wb_data = ctrl.wb_mdr ? mdr : alu_result;

    // Compare result of zero means equal or not less than
    assign zero        = (alu_result == '0);
    assign take_branch = ctrl.branch & (zero ^ ctrl.branch_invert);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc      <= '0;
            old_pc  <= '0;
            ir.raw  <= '0;
            a       <= '0;
            b       <= '0;
            alu_out <= '0;
            mdr     <= '0;
        end else begin
            if (ctrl.pc_write) begin
                pc <= alu_result;
            end else if (take_branch) begin
                pc <= alu_out;      // Target computed in decode
            end
            if (ctrl.ir_write) begin
                ir.raw <= mem_rdata;
                old_pc <= pc;
            end
            a       <= rdata1;
            b       <= rdata2;
            alu_out <= alu_result;
            mdr     <= mem_rdata;
        end
    end

    assign mem_req.addr  = ctrl.iord ? alu_out : pc;
    assign mem_req.wdata = b;
    assign mem_req.read  = ctrl.mem_read;
    assign mem_req.write = ctrl.mem_write;

    assign instr = ir;

endmodule

// ==== hw/control_fsm.sv ====
// Multi-cycle control FSM with state register, next-state logic and control word decode
`timescale 1ns/1ps

module control_fsm import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  instr_t instr,
    output ctrl_t  ctrl
);

    state_e     state;
    state_e     state_next;
    logic [6:0] opcode;

    assign opcode = instr.r.opcode;

    // ALU operation and operands of an OP, OP-IMM, LOAD or STORE
    function automatic ctrl_t exec_word(instr_t ins);
        ctrl_t w;
        logic  is_op;
        w     = ctrl_idle_c;
        is_op = (ins.r.opcode == op_op_c);
        w.src_a = src_a_rs1;
        w.src_b = is_op ? src_b_rs2 : src_b_imm;
        if (is_op || ins.r.opcode == op_op_imm_c) begin
            case (ins.r.funct3)
                f3_add_c:  w.alu_op = (is_op && ins.r.funct7[alt_bit_c]) ? alu_sub : alu_add;
                f3_sll_c:  w.alu_op = alu_sll;
                f3_slt_c:  w.alu_op = alu_slt;
                f3_sltu_c: w.alu_op = alu_sltu;
                f3_xor_c:  w.alu_op = alu_xor;
                f3_sr_c:   w.alu_op = ins.r.funct7[alt_bit_c] ? alu_sra : alu_srl;
                f3_or_c:   w.alu_op = alu_or;
                f3_and_c:  w.alu_op = alu_and;
                default:   w.alu_op = alu_add;
            endcase
        end
        return w;   // Loads and stores keep add for the address
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= state_fetch;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state_fetch;
        case (state)
            state_fetch: state_next = state_decode;
            state_decode: begin
                case (opcode)
                    op_op_c, op_op_imm_c, op_load_c, op_store_c: state_next = state_execute;
                    op_branch_c: state_next = state_branch;
                    op_lui_c:    state_next = state_lui;
                    default:     state_next = state_fetch; // Unknown opcode is skipped
                endcase
            end
            state_execute: begin
                if (opcode == op_load_c || opcode == op_store_c) begin
                    state_next = state_memory;
                end else begin
                    state_next = state_writeback;
                end
            end
            state_memory: state_next = (opcode == op_load_c) ? state_writeback : state_fetch;
            default:      state_next = state_fetch;
        endcase
    end

    always_comb begin
        ctrl = ctrl_idle_c;
        case (state)
            state_fetch: begin
                ctrl.mem_read = 1'b1;
                ctrl.ir_write = 1'b1;
                ctrl.src_a    = src_a_pc;
                ctrl.src_b    = src_b_four;
                ctrl.pc_write = 1'b1;
            end
            state_decode: begin
                // Branch target into alu_out
                ctrl.src_a = src_a_old_pc;
                ctrl.src_b = src_b_imm;
            end
            state_execute: ctrl = exec_word(instr);
            state_memory: begin
                ctrl.iord      = 1'b1;
                ctrl.mem_read  = (opcode == op_load_c);
                ctrl.mem_write = (opcode == op_store_c);
            end
            state_writeback: begin
                // ALU work of execute repeated so the result goes straight to rd
                ctrl           = exec_word(instr);
                ctrl.reg_write = 1'b1;
                ctrl.wb_mdr    = (opcode == op_load_c);
            end
            state_branch: begin
                ctrl.src_a  = src_a_rs1;
                ctrl.src_b  = src_b_rs2;
                ctrl.branch = 1'b1;
                case (instr.b.funct3)
                    f3_beq_c:  ctrl.alu_op = alu_sub;
                    f3_bne_c: begin
                        ctrl.alu_op        = alu_sub;
                        ctrl.branch_invert = 1'b1;
                    end
                    f3_blt_c: begin
                        ctrl.alu_op        = alu_slt;
                        ctrl.branch_invert = 1'b1;
                    end
                    f3_bge_c:  ctrl.alu_op = alu_slt;
                    f3_bltu_c: begin
                        ctrl.alu_op        = alu_sltu;
                        ctrl.branch_invert = 1'b1;
                    end
                    f3_bgeu_c: ctrl.alu_op = alu_sltu;
                    default:   ctrl.branch = 1'b0;  // Reserved funct3 is never taken
                endcase
            end
            state_lui: begin
                ctrl.src_a     = src_a_zero;
                ctrl.src_b     = src_b_imm;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl = ctrl_idle_c;
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
// Register file with 31 writable registers and a zero register x0
`timescale 1ns/1ps

module reg_file import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      we,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [1:31];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hw/imm_gen.sv ====
// Immediate generator for the I, S, B and U instruction formats
`timescale 1ns/1ps

module imm_gen import rv_isa_pkg::*; (
    input  instr_t instr,
    output word_t  imm
);

    always_comb begin
        case (instr.i.opcode)
            op_op_imm_c, op_load_c: begin
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            op_store_c: begin
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            op_branch_c: begin
                // Offset in halfwords, low bit always zero
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            op_lui_c: imm = {instr.u.imm_31_12, 12'b0};
            default:  imm = '0;  // R-type and unknown
        endcase
    end

endmodule

// ==== hw/alu.sv ====
// 32-bit integer ALU for the RV32I arithmetic, logic, shift and compare operations
`timescale 1ns/1ps

module alu import rv_isa_pkg::*, core_ctrl_pkg::*; (
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // Upper bits of the amount are ignored

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'b0, a < b};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

// ==== hw/core_ctrl_pkg.sv ====
// Core FSM states, ALU operations, operand selects, control word and memory request
package core_ctrl_pkg;
    import rv_isa_pkg::*;

    typedef enum logic [2:0] {
        state_fetch,
        state_decode,
        state_execute,
        state_memory,
        state_writeback,
        state_branch,
        state_lui
    } state_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    typedef enum logic [1:0] {
        src_a_pc,
        src_a_old_pc,   // PC of the instruction in the IR
        src_a_rs1,
        src_a_zero
    } src_a_e;

    typedef enum logic [1:0] {
        src_b_rs2,
        src_b_four,
        src_b_imm
    } src_b_e;

    typedef struct packed {
        logic    pc_write;      // PC <= ALU result
        logic    branch;        // PC <= alu_out when condition holds
        logic    branch_invert; // Taken on nonzero compare result
        logic    iord;          // Address from alu_out, else PC
        logic    ir_write;
        src_a_e  src_a;
        src_b_e  src_b;
        alu_op_e alu_op;
        logic    reg_write;
        logic    wb_mdr;        // Write back mdr, else the ALU result
        logic    mem_read;
        logic    mem_write;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  read;
        logic  write;
    } mem_req_t;

    localparam word_t pc_step_c = 32'd4;

    // Nothing written, nothing strobed
    localparam ctrl_t ctrl_idle_c = '{
        pc_write: 1'b0, branch: 1'b0, branch_invert: 1'b0, iord: 1'b0,
        ir_write: 1'b0, src_a: src_a_pc, src_b: src_b_rs2, alu_op: alu_add,
        reg_write: 1'b0, wb_mdr: 1'b0, mem_read: 1'b0, mem_write: 1'b0
    };

endpackage

// ==== hw/rv_isa_pkg.sv ====
// RV32I data types, instruction format structs, instruction union, opcodes and funct codes
package rv_isa_pkg;

    localparam int xlen_c = 32;             // Width of one integer word

    typedef logic [4:0]        reg_addr_t;
    typedef logic [xlen_c-1:0] word_t;

    // Major opcodes of the supported instructions
    localparam logic [6:0] op_lui_c    = 7'b0110111;
    localparam logic [6:0] op_op_c     = 7'b0110011; // R-type ALU
    localparam logic [6:0] op_op_imm_c = 7'b0010011; // I-type ALU
    localparam logic [6:0] op_load_c   = 7'b0000011;
    localparam logic [6:0] op_store_c  = 7'b0100011;
    localparam logic [6:0] op_branch_c = 7'b1100011;

    // ALU funct3, shared by OP and OP-IMM
    localparam logic [2:0] f3_add_c  = 3'b000;       // ADD/SUB
    localparam logic [2:0] f3_sll_c  = 3'b001;
    localparam logic [2:0] f3_slt_c  = 3'b010;
    localparam logic [2:0] f3_sltu_c = 3'b011;
    localparam logic [2:0] f3_xor_c  = 3'b100;
    localparam logic [2:0] f3_sr_c   = 3'b101;       // SRL/SRA
    localparam logic [2:0] f3_or_c   = 3'b110;
    localparam logic [2:0] f3_and_c  = 3'b111;

    // Branch funct3
    localparam logic [2:0] f3_beq_c  = 3'b000;
    localparam logic [2:0] f3_bne_c  = 3'b001;
    localparam logic [2:0] f3_blt_c  = 3'b100;
    localparam logic [2:0] f3_bge_c  = 3'b101;
    localparam logic [2:0] f3_bltu_c = 3'b110;
    localparam logic [2:0] f3_bgeu_c = 3'b111;

    localparam int alt_bit_c = 5;           // funct7 bit for SUB and SRA

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One fetched word, seen through each format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        word_t  raw;
    } instr_t;

endpackage
